// ==== common/pipe_consts.svh ====
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// Datapath dimensions
`define DATA_WIDTH 32
`define REG_ADDR_W 5
`define NUM_REGS   32
`define SHAMT_W    5

// Opcodes
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_XORI  6'h0e
`define OP_LUI   6'h0f

// R-type funct codes
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_SRA  6'h03
`define FN_SLLV 6'h04
`define FN_SRLV 6'h06
`define FN_SRAV 6'h07
`define FN_MOVZ 6'h0a
`define FN_MOVN 6'h0b
`define FN_ADD  6'h20
`define FN_ADDU 6'h21
`define FN_SUB  6'h22
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_NOR  6'h27
`define FN_SLT  6'h2a
`define FN_SLTU 6'h2b

`endif

// ==== common/pipe_pkg.sv ====
`default_nettype none

`include "pipe_consts.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SHIFT_SLL,
        SHIFT_SRL,
        SHIFT_SRA
    } shift_op_e;

    typedef enum logic [1:0] {
        EXRES_ALU,
        EXRES_SHIFT,
        EXRES_PASS_A
    } exres_sel_e;

    typedef enum logic [1:0] {
        MOV_NONE,
        MOV_MOVZ,
        MOV_MOVN
    } mov_e;

    // Decode to execute
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] op_a;
        logic [`DATA_WIDTH-1:0] op_b;
        logic [`REG_ADDR_W-1:0] rs_addr;
        logic [`REG_ADDR_W-1:0] rt_addr;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`DATA_WIDTH-1:0] imm_ext;
        logic [`SHAMT_W-1:0]    shamt;
        logic                   shamt_sel;
        logic                   b_sel;
        alu_op_e                alu_op;
        shift_op_e              shift_op;
        exres_sel_e             exres_sel;
        mov_e                   mov;
        logic                   reg_w;
        logic                   of_w_disable;
    } idex_t;

    // Execute to write-back
    typedef struct packed {
        logic                   reg_w;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`DATA_WIDTH-1:0] result;
    } exwb_t;

endpackage

`default_nettype wire

// ==== src/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     ui_clk_from_ddr,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // No stalls, so the payload moves every cycle
    always_ff @(posedge ui_clk_from_ddr) begin
        out_data <= in_data;
    end

endmodule

`default_nettype wire

// ==== src/gpr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module gpr (
    input  logic                   ui_clk_from_ddr,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic [`REG_ADDR_W-1:0] rt_addr,
    output logic [`DATA_WIDTH-1:0] rs_data,
    output logic [`DATA_WIDTH-1:0] rt_data,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`DATA_WIDTH-1:0] wr_data
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module decoder (
    input  logic [`DATA_WIDTH-1:0] instr,
    input  logic                   instr_valid,
    output logic [`REG_ADDR_W-1:0] rs_addr,
    output logic [`REG_ADDR_W-1:0] rt_addr,
    output pipe_pkg::idex_t        ctrl,
    output logic                   valid
);

    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [15:0]            imm;
    logic [`REG_ADDR_W-1:0] rd_field;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   supported;

    assign opcode   = instr[31:26];
    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];
    assign rd_field = instr[15:11];
    assign funct    = instr[5:0];
    assign imm      = instr[15:0];
    assign valid    = instr_valid;

    always_comb begin
        // Operands are filled in at the top level
        ctrl           = '0;
        ctrl.rs_addr   = rs_addr;
        ctrl.rt_addr   = rt_addr;
        ctrl.shamt     = instr[10:6];
        ctrl.imm_ext   = {{(`DATA_WIDTH-16){imm[15]}}, imm};
        ctrl.alu_op    = pipe_pkg::ALU_ADD;
        ctrl.shift_op  = pipe_pkg::SHIFT_SLL;
        ctrl.exres_sel = pipe_pkg::EXRES_ALU;
        ctrl.mov       = pipe_pkg::MOV_NONE;
        dest           = rt_addr;
        supported      = 1'b1;

        case (opcode)
            `OP_RTYPE: begin
                dest = rd_field;
                case (funct)
                    `FN_ADD: begin
                        ctrl.alu_op       = pipe_pkg::ALU_ADD;
                        ctrl.of_w_disable = 1'b1;
                    end
                    `FN_ADDU: ctrl.alu_op = pipe_pkg::ALU_ADD;
                    `FN_SUB: begin
                        ctrl.alu_op       = pipe_pkg::ALU_SUB;
                        ctrl.of_w_disable = 1'b1;
                    end
                    `FN_SUBU: ctrl.alu_op = pipe_pkg::ALU_SUB;
                    `FN_AND:  ctrl.alu_op = pipe_pkg::ALU_AND;
                    `FN_OR:   ctrl.alu_op = pipe_pkg::ALU_OR;
                    `FN_XOR:  ctrl.alu_op = pipe_pkg::ALU_XOR;
                    `FN_NOR:  ctrl.alu_op = pipe_pkg::ALU_NOR;
                    `FN_SLT:  ctrl.alu_op = pipe_pkg::ALU_SLT;
                    `FN_SLTU: ctrl.alu_op = pipe_pkg::ALU_SLTU;
                    // Shifts, fixed then variable amount
                    `FN_SLL, `FN_SRL, `FN_SRA,
                    `FN_SLLV, `FN_SRLV, `FN_SRAV: begin
                        ctrl.exres_sel = pipe_pkg::EXRES_SHIFT;
                        ctrl.shamt_sel = funct[2];
                        case (funct[1:0])
                            2'b10:   ctrl.shift_op = pipe_pkg::SHIFT_SRL;
                            2'b11:   ctrl.shift_op = pipe_pkg::SHIFT_SRA;
                            default: ctrl.shift_op = pipe_pkg::SHIFT_SLL;
                        endcase
                    end
                    `FN_MOVZ, `FN_MOVN: begin
                        ctrl.exres_sel = pipe_pkg::EXRES_PASS_A;
                        ctrl.mov       = funct[0] ? pipe_pkg::MOV_MOVN : pipe_pkg::MOV_MOVZ;
                    end
                    default: supported = 1'b0;
                endcase
            end
            `OP_ADDI:  ctrl.of_w_disable = 1'b1;
            `OP_ADDIU: ctrl.alu_op = pipe_pkg::ALU_ADD;
            `OP_SLTI:  ctrl.alu_op = pipe_pkg::ALU_SLT;
            // Logical immediates are zero extended
            `OP_ANDI, `OP_ORI, `OP_XORI: begin
                ctrl.imm_ext = {{(`DATA_WIDTH-16){1'b0}}, imm};
                case (opcode[1:0])
                    2'b00:   ctrl.alu_op = pipe_pkg::ALU_AND;
                    2'b01:   ctrl.alu_op = pipe_pkg::ALU_OR;
                    default: ctrl.alu_op = pipe_pkg::ALU_XOR;
                endcase
            end
            // Raw immediate, ALU moves it to the upper half
            `OP_LUI: begin
                ctrl.imm_ext = {{(`DATA_WIDTH-16){1'b0}}, imm};
                ctrl.alu_op  = pipe_pkg::ALU_LUI;
            end
            default: supported = 1'b0;
        endcase

        ctrl.b_sel   = (opcode != `OP_RTYPE);
        ctrl.rd_addr = dest;
        ctrl.reg_w   = instr_valid && supported && (dest != '0);
    end

endmodule

`default_nettype wire

// ==== ex/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  pipe_pkg::alu_op_e      op,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero,
    output logic                   less,
    output logic                   overflow
);

    localparam int MSB  = `DATA_WIDTH - 1;
    localparam int HALF = `DATA_WIDTH / 2;

    logic [`DATA_WIDTH-1:0] sum;
    logic [`DATA_WIDTH-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed compare unless sltu
    assign less = (op == pipe_pkg::ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            pipe_pkg::ALU_ADD: overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            pipe_pkg::ALU_SUB: overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
            default:           overflow = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            pipe_pkg::ALU_ADD:  result = sum;
            pipe_pkg::ALU_SUB:  result = diff;
            pipe_pkg::ALU_AND:  result = a & b;
            pipe_pkg::ALU_OR:   result = a | b;
            pipe_pkg::ALU_XOR:  result = a ^ b;
            pipe_pkg::ALU_NOR:  result = ~(a | b);
            pipe_pkg::ALU_SLT,
            pipe_pkg::ALU_SLTU: result = {{MSB{1'b0}}, less};
            pipe_pkg::ALU_LUI:  result = {b[HALF-1:0], {HALF{1'b0}}};
            default:            result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== ex/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module barrel_shifter (
    input  logic [`DATA_WIDTH-1:0] data,
    input  logic [`SHAMT_W-1:0]    amount,
    input  pipe_pkg::shift_op_e    op,
    output logic [`DATA_WIDTH-1:0] result
);

    logic                   right;
    logic [`DATA_WIDTH-1:0] fill;

    assign right = (op == pipe_pkg::SHIFT_SRL) || (op == pipe_pkg::SHIFT_SRA);
    // All ones for sra of a negative value
    assign fill  = {`DATA_WIDTH{(op == pipe_pkg::SHIFT_SRA) && data[`DATA_WIDTH-1]}};

    // Five stages of 1, 2, 4, 8 and 16 bits
    always_comb begin
        result = data;
        for (int i = 0; i < `SHAMT_W; i++) begin
            if (amount[i] && right) begin
                result = (result >> (1 << i)) | (fill & ~(fill >> (1 << i)));
            end else if (amount[i]) begin
                result = result << (1 << i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== ex/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module ex_stage (
    input  pipe_pkg::idex_t        idex,
    input  logic                   idex_valid,
    input  logic                   fwd_reg_w,
    input  logic [`REG_ADDR_W-1:0] fwd_rd_addr,
    input  logic [`DATA_WIDTH-1:0] fwd_data,
    output pipe_pkg::exwb_t        exwb
);

    logic [`DATA_WIDTH-1:0] op_a_fwd;
    logic [`DATA_WIDTH-1:0] op_b_fwd;
    logic [`DATA_WIDTH-1:0] alu_a;
    logic [`DATA_WIDTH-1:0] alu_b;
    logic [`SHAMT_W-1:0]    shift_amount;
    logic [`DATA_WIDTH-1:0] alu_result;
    logic [`DATA_WIDTH-1:0] shift_result;
    logic                   alu_zero;
    logic                   alu_overflow;

    ////////////////////////////////////////////////////////////////////
    // Forwarding from write-back and operand selection
    ////////////////////////////////////////////////////////////////////

    assign op_a_fwd = (fwd_reg_w && fwd_rd_addr == idex.rs_addr) ? fwd_data : idex.op_a;
    assign op_b_fwd = (fwd_reg_w && fwd_rd_addr == idex.rt_addr) ? fwd_data : idex.op_b;

    // movz/movn compute 0 + rt so the zero flag tests rt
    assign alu_a        = (idex.mov != pipe_pkg::MOV_NONE) ? '0 : op_a_fwd;
    assign alu_b        = idex.b_sel ? idex.imm_ext : op_b_fwd;
    assign shift_amount = idex.shamt_sel ? op_a_fwd[`SHAMT_W-1:0] : idex.shamt;

    alu u_alu (
        .a        ( alu_a          ),
        .b        ( alu_b          ),
        .op       ( idex.alu_op    ),
        .result   ( alu_result     ),
        .zero     ( alu_zero       ),
        .less     (                ),
        .overflow ( alu_overflow   )
    );

    barrel_shifter u_barrel_shifter (
        .data   ( op_b_fwd      ),
        .amount ( shift_amount  ),
        .op     ( idex.shift_op ),
        .result ( shift_result  )
    );

    ////////////////////////////////////////////////////////////////////
    // Result and write enable
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        exwb.rd_addr = idex.rd_addr;
        case (idex.exres_sel)
            pipe_pkg::EXRES_SHIFT:  exwb.result = shift_result;
            pipe_pkg::EXRES_PASS_A: exwb.result = op_a_fwd;
            default:                exwb.result = alu_result;
        endcase

        exwb.reg_w = idex_valid && idex.reg_w;
        if (idex.of_w_disable && alu_overflow) begin
            exwb.reg_w = 1'b0;
        end
        if (idex.mov == pipe_pkg::MOV_MOVZ && !alu_zero) begin
            exwb.reg_w = 1'b0;
        end
        if (idex.mov == pipe_pkg::MOV_MOVN && alu_zero) begin
            exwb.reg_w = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/exec_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module exec_pipeline (
    input  logic                   ui_clk_from_ddr,
    input  logic                   rst_n,
    input  logic [`DATA_WIDTH-1:0] instr,
    input  logic                   instr_valid,
    output logic                   wb_valid,
    output logic                   wb_reg_w,
    output logic [`REG_ADDR_W-1:0] wb_rd_addr,
    output logic [`DATA_WIDTH-1:0] wb_data
);

    pipe_pkg::idex_t        dec_ctrl;
    logic                   dec_valid;
    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic [`DATA_WIDTH-1:0] rs_data;
    logic [`DATA_WIDTH-1:0] rt_data;
    pipe_pkg::idex_t        idex_d;
    pipe_pkg::idex_t        idex_q;
    logic                   idex_valid;
    pipe_pkg::exwb_t        exwb_d;
    pipe_pkg::exwb_t        exwb_q;

    ////////////////////////////////////////////////////////////////////
    // Decode and register read
    ////////////////////////////////////////////////////////////////////

    decoder u_decoder (
        .instr       ( instr       ),
        .instr_valid ( instr_valid ),
        .rs_addr     ( rs_addr     ),
        .rt_addr     ( rt_addr     ),
        .ctrl        ( dec_ctrl    ),
        .valid       ( dec_valid   )
    );

    // Write port comes straight from EX/WB
    gpr u_gpr (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .rs_addr         ( rs_addr         ),
        .rt_addr         ( rt_addr         ),
        .rs_data         ( rs_data         ),
        .rt_data         ( rt_data         ),
        .wr_en           ( wb_reg_w        ),
        .wr_addr         ( wb_rd_addr      ),
        .wr_data         ( wb_data         )
    );

    always_comb begin
        idex_d      = dec_ctrl;
        idex_d.op_a = rs_data;
        idex_d.op_b = rt_data;
    end

    stage_reg #(.payload_t(pipe_pkg::idex_t)) u_idex_reg (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .in_valid        ( dec_valid       ),
        .in_data         ( idex_d          ),
        .out_valid       ( idex_valid      ),
        .out_data        ( idex_q          )
    );

    ////////////////////////////////////////////////////////////////////
    // Execute and write-back
    ////////////////////////////////////////////////////////////////////

    ex_stage u_ex_stage (
        .idex        ( idex_q     ),
        .idex_valid  ( idex_valid ),
        .fwd_reg_w   ( wb_reg_w   ),
        .fwd_rd_addr ( wb_rd_addr ),
        .fwd_data    ( wb_data    ),
        .exwb        ( exwb_d     )
    );

    stage_reg #(.payload_t(pipe_pkg::exwb_t)) u_exwb_reg (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .in_valid        ( idex_valid      ),
        .in_data         ( exwb_d          ),
        .out_valid       ( wb_valid        ),
        .out_data        ( exwb_q          )
    );

    assign wb_reg_w   = exwb_q.reg_w;
    assign wb_rd_addr = exwb_q.rd_addr;
    assign wb_data    = exwb_q.result;

endmodule

`default_nettype wire

// ==== verification/exec_pipeline_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module exec_pipeline_assert (
    input logic                   ui_clk_from_ddr,
    input logic                   rst_n,
    input logic                   wb_valid,
    input logic                   wb_reg_w,
    input logic [`REG_ADDR_W-1:0] wb_rd_addr
);

    // A register write always belongs to a retiring instruction
    a_write_has_valid: assert property (
        @(posedge ui_clk_from_ddr) disable iff (!rst_n) wb_reg_w |-> wb_valid
    ) else $error("wb_reg_w high while wb_valid is low");

    // Register 0 is never a destination
    a_no_r0_write: assert property (
        @(posedge ui_clk_from_ddr) disable iff (!rst_n) wb_reg_w |-> (wb_rd_addr != '0)
    ) else $error("write-back targets register 0");

    // Pipeline comes out of reset empty
    a_empty_after_reset: assert property (
        @(posedge ui_clk_from_ddr) !rst_n |=> !wb_valid
    ) else $error("wb_valid high in the cycle after reset");

endmodule

bind exec_pipeline exec_pipeline_assert u_exec_pipeline_assert (
    .ui_clk_from_ddr ( ui_clk_from_ddr ),
    .rst_n           ( rst_n           ),
    .wb_valid        ( wb_valid        ),
    .wb_reg_w        ( wb_reg_w        ),
    .wb_rd_addr      ( wb_rd_addr      )
);

`default_nettype wire

// ==== verification/tb_exec_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module tb_exec_pipeline;

    localparam int MAX_CYCLES = 2000;

    // Supported funct and I-type opcodes for the random mix
    localparam logic [18*6-1:0] FN_TABLE = {
        `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
        `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
        `FN_MOVZ, `FN_MOVN
    };
    localparam logic [7*6-1:0] OP_TABLE = {
        `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI
    };

    logic                   ui_clk_from_ddr;
    logic                   rst_n;
    logic [`DATA_WIDTH-1:0] instr;
    logic                   instr_valid;
    logic                   wb_valid;
    logic                   wb_reg_w;
    logic [`REG_ADDR_W-1:0] wb_rd_addr;
    logic [`DATA_WIDTH-1:0] wb_data;

    logic [`DATA_WIDTH-1:0] shadow [`NUM_REGS];
    int unsigned            cycle = 0;
    int unsigned            due_q [$];
    logic                   exp_we_q [$];
    logic [`REG_ADDR_W-1:0] exp_rd_q [$];
    logic [`DATA_WIDTH-1:0] exp_data_q [$];
    logic                   exp_we;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic [`DATA_WIDTH-1:0] exp_data;
    int                     checks = 0;
    int                     errors = 0;
    int                     test_err_start = 0;

    exec_pipeline u_exec_pipeline (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .instr           ( instr           ),
        .instr_valid     ( instr_valid     ),
        .wb_valid        ( wb_valid        ),
        .wb_reg_w        ( wb_reg_w        ),
        .wb_rd_addr      ( wb_rd_addr      ),
        .wb_data         ( wb_data         )
    );

    initial begin
        ui_clk_from_ddr = 1'b0;
        forever #2 ui_clk_from_ddr = ~ui_clk_from_ddr;
    end

    always @(posedge ui_clk_from_ddr) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d results never retired", cycle, due_q.size());
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Returns {write enable, destination, result}
    function automatic logic [37:0] ref_model(input logic [31:0] ins);
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] res;
        logic [32:0] wide;
        logic        we;
        logic [4:0]  dest;
        opcode = ins[31:26];
        rs     = ins[25:21];
        rt     = ins[20:16];
        rd     = ins[15:11];
        sa     = ins[10:6];
        funct  = ins[5:0];
        imm    = ins[15:0];
        a      = shadow[rs];
        b      = shadow[rt];
        sext   = {{16{imm[15]}}, imm};
        zext   = {16'h0000, imm};
        we     = 1'b1;
        dest   = rt;
        res    = '0;
        case (opcode)
            `OP_RTYPE: begin
                dest = rd;
                case (funct)
                    // Signed overflow when the two top bits of the 33-bit sum differ
                    `FN_ADD: begin
                        wide = {a[31], a} + {b[31], b};
                        res  = wide[31:0];
                        we   = (wide[32] == wide[31]);
                    end
                    `FN_SUB: begin
                        wide = {a[31], a} - {b[31], b};
                        res  = wide[31:0];
                        we   = (wide[32] == wide[31]);
                    end
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_NOR:  res = ~(a | b);
                    `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    `FN_SLL:  res = b << sa;
                    `FN_SRL:  res = b >> sa;
                    `FN_SRA:  res = $signed(b) >>> sa;
                    `FN_SLLV: res = b << a[4:0];
                    `FN_SRLV: res = b >> a[4:0];
                    `FN_SRAV: res = $signed(b) >>> a[4:0];
                    `FN_MOVZ: begin
                        res = a;
                        we  = (b == 32'd0);
                    end
                    `FN_MOVN: begin
                        res = a;
                        we  = (b != 32'd0);
                    end
                    default:  we = 1'b0;
                endcase
            end
            `OP_ADDI: begin
                wide = {a[31], a} + {sext[31], sext};
                res  = wide[31:0];
                we   = (wide[32] == wide[31]);
            end
            `OP_ADDIU: res = a + sext;
            `OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            `OP_ANDI:  res = a & zext;
            `OP_ORI:   res = a | zext;
            `OP_XORI:  res = a ^ zext;
            `OP_LUI:   res = {imm, 16'h0000};
            default:   we = 1'b0;
        endcase
        if (dest == 5'd0) begin
            we = 1'b0;
        end
        return {we, dest, res};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        int          k;
        w        = $urandom;
        k        = $urandom % 25;
        // Few registers so that dependencies are frequent
        w[25:21] = $urandom % 8;
        w[20:16] = $urandom % 8;
        if (k < 18) begin
            w[31:26] = `OP_RTYPE;
            w[15:11] = $urandom % 8;
            w[5:0]   = FN_TABLE[k*6 +: 6];
        end else begin
            w[31:26] = OP_TABLE[(k-18)*6 +: 6];
        end
        return w;
    endfunction

    // lw opcode or mult funct
    function automatic logic [31:0] unsupported_instr();
        logic [31:0] w;
        w = $urandom;
        if (w[0]) begin
            w[31:26] = 6'h23;
        end else begin
            w[31:26] = `OP_RTYPE;
            w[5:0]   = 6'h18;
        end
        return w;
    endfunction

    task automatic issue(input logic [31:0] ins, input logic v);
        logic [37:0] r;
        @(posedge ui_clk_from_ddr);
        #1;
        instr       = ins;
        instr_valid = v;
        if (v) begin
            r = ref_model(ins);
            // Retires two edges after the one that samples it
            due_q.push_back(cycle + 2);
            exp_we_q.push_back(r[37]);
            exp_rd_q.push_back(r[36:32]);
            exp_data_q.push_back(r[31:0]);
            if (r[37]) begin
                shadow[r[36:32]] = r[31:0];
            end
        end
    endtask

    task automatic load_reg(input logic [4:0] rt, input logic [31:0] value);
        issue(itype(`OP_LUI, 5'd0, rt, value[31:16]), 1'b1);
        issue(itype(`OP_ORI, rt, rt, value[15:0]), 1'b1);
    endtask

    task automatic finish_test(input int num, input string name);
        @(posedge ui_clk_from_ddr);
        #1;
        instr_valid = 1'b0;
        while (due_q.size() != 0) begin
            @(posedge ui_clk_from_ddr);
        end
        repeat (2) @(posedge ui_clk_from_ddr);
        $display("Test %0d (%s) done with %0d errors", num, name, errors - test_err_start);
        test_err_start = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Write-back comparison
    //////////////////////////////////////////////////////////////////////

    always @(negedge ui_clk_from_ddr) begin
        if (rst_n) begin
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                void'(due_q.pop_front());
                exp_we   = exp_we_q.pop_front();
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                checks++;
                if (wb_valid !== 1'b1) begin
                    errors++;
                    $display("Error at %0t: wb_valid expected 1, actual %b", $time, wb_valid);
                end else if (wb_reg_w !== exp_we) begin
                    errors++;
                    $display("Error at %0t: wb_reg_w expected %b, actual %b",
                             $time, exp_we, wb_reg_w);
                end else if (exp_we && (wb_rd_addr !== exp_rd || wb_data !== exp_data)) begin
                    errors++;
                    $display("Error at %0t: write-back expected r%0d=%h, actual r%0d=%h",
                             $time, exp_rd, exp_data, wb_rd_addr, wb_data);
                end
            end else if (wb_valid !== 1'b0) begin
                errors++;
                $display("Error at %0t: wb_valid expected 0 for a bubble, actual %b",
                         $time, wb_valid);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          kind;
        logic [31:0] d;
        void'($urandom(32'h80b0));
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge ui_clk_from_ddr);
        #1;
        rst_n = 1'b1;

        // Sign and zero extension of immediates
        issue(itype(`OP_ADDIU, 5'd0, 5'd1, 16'h1234), 1'b1);
        issue(itype(`OP_ADDIU, 5'd0, 5'd2, 16'h8001), 1'b1);
        issue(itype(`OP_ORI, 5'd0, 5'd3, 16'hf00f), 1'b1);
        load_reg(5'd4, 32'hdeadbeef);
        issue(itype(`OP_ADDIU, 5'd0, 5'd5, 16'hffff), 1'b1);
        load_reg(5'd6, 32'h7fffffff);
        issue(itype(`OP_LUI, 5'd0, 5'd7, 16'h8000), 1'b1);
        issue(itype(`OP_ANDI, 5'd5, 5'd8, 16'h8421), 1'b1);
        issue(itype(`OP_XORI, 5'd2, 5'd9, 16'hffff), 1'b1);
        finish_test(1, "immediate loads");

        // Each uses the previous one or two results
        issue(rtype(5'd1, 5'd3, 5'd10, 5'd0, `FN_ADD), 1'b1);
        issue(rtype(5'd10, 5'd1, 5'd11, 5'd0, `FN_SUB), 1'b1);
        issue(rtype(5'd11, 5'd10, 5'd12, 5'd0, `FN_AND), 1'b1);
        issue(rtype(5'd12, 5'd11, 5'd13, 5'd0, `FN_OR), 1'b1);
        issue(rtype(5'd13, 5'd12, 5'd14, 5'd0, `FN_XOR), 1'b1);
        issue(rtype(5'd14, 5'd13, 5'd15, 5'd0, `FN_NOR), 1'b1);
        issue(rtype(5'd15, 5'd14, 5'd16, 5'd0, `FN_ADDU), 1'b1);
        issue(rtype(5'd16, 5'd15, 5'd17, 5'd0, `FN_SUBU), 1'b1);
        issue(rtype(5'd17, 5'd17, 5'd18, 5'd0, `FN_ADD), 1'b1);
        finish_test(2, "dependent chain");

        for (int j = 0; j < 8; j++) begin
            d = $urandom;
            load_reg(5'd20, d);
            issue(itype(`OP_ADDIU, 5'd0, 5'd21, $urandom), 1'b1);
            issue(rtype(5'd0, 5'd20, 5'd22, $urandom, `FN_SLL), 1'b1);
            issue(rtype(5'd0, 5'd20, 5'd23, $urandom, `FN_SRL), 1'b1);
            issue(rtype(5'd0, 5'd20, 5'd24, $urandom, `FN_SRA), 1'b1);
            issue(rtype(5'd21, 5'd20, 5'd25, 5'd0, `FN_SLLV), 1'b1);
            issue(rtype(5'd21, 5'd20, 5'd26, 5'd0, `FN_SRLV), 1'b1);
            issue(rtype(5'd21, 5'd20, 5'd27, 5'd0, `FN_SRAV), 1'b1);
        end
        finish_test(3, "shifts");

        // Overflowing results must leave the destination alone
        issue(itype(`OP_ADDIU, 5'd0, 5'd14, 16'h0055), 1'b1);
        issue(itype(`OP_ADDIU, 5'd0, 5'd15, 16'h0066), 1'b1);
        issue(itype(`OP_ADDIU, 5'd0, 5'd16, 16'h0077), 1'b1);
        issue(rtype(5'd6, 5'd6, 5'd14, 5'd0, `FN_ADD), 1'b1);
        issue(rtype(5'd7, 5'd6, 5'd15, 5'd0, `FN_SUB), 1'b1);
        issue(itype(`OP_ADDI, 5'd6, 5'd16, 16'h0001), 1'b1);
        issue(rtype(5'd14, 5'd0, 5'd17, 5'd0, `FN_OR), 1'b1);
        issue(rtype(5'd15, 5'd0, 5'd18, 5'd0, `FN_OR), 1'b1);
        issue(rtype(5'd16, 5'd0, 5'd19, 5'd0, `FN_OR), 1'b1);
        issue(rtype(5'd6, 5'd6, 5'd14, 5'd0, `FN_ADDU), 1'b1);
        issue(rtype(5'd7, 5'd6, 5'd15, 5'd0, `FN_SUBU), 1'b1);
        finish_test(4, "overflow");

        issue(rtype(5'd4, 5'd0, 5'd19, 5'd0, `FN_MOVZ), 1'b1);
        issue(rtype(5'd1, 5'd2, 5'd19, 5'd0, `FN_MOVZ), 1'b1);
        issue(rtype(5'd4, 5'd2, 5'd20, 5'd0, `FN_MOVN), 1'b1);
        issue(rtype(5'd1, 5'd0, 5'd20, 5'd0, `FN_MOVN), 1'b1);
        issue(rtype(5'd19, 5'd20, 5'd21, 5'd0, `FN_OR), 1'b1);
        issue(rtype(5'd2, 5'd1, 5'd22, 5'd0, `FN_SLT), 1'b1);
        issue(rtype(5'd2, 5'd1, 5'd23, 5'd0, `FN_SLTU), 1'b1);
        issue(rtype(5'd1, 5'd2, 5'd26, 5'd0, `FN_SLTU), 1'b1);
        issue(itype(`OP_SLTI, 5'd1, 5'd24, 16'hffff), 1'b1);
        issue(itype(`OP_SLTI, 5'd2, 5'd25, 16'h0005), 1'b1);
        finish_test(5, "conditional moves and compares");

        // Mix of bubbles, unsupported codes and supported instructions
        for (int i = 0; i < 500; i++) begin
            kind = $urandom % 20;
            if (kind == 0) begin
                issue($urandom, 1'b0);
            end else if (kind == 1) begin
                issue(unsupported_instr(), 1'b1);
            end else begin
                issue(random_instr(), 1'b1);
            end
        end
        finish_test(6, "random mix");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/pipe_pkg.sv
src/stage_reg.sv
src/gpr.sv
src/decoder.sv
ex/alu.sv
ex/barrel_shifter.sv
ex/ex_stage.sv
src/exec_pipeline.sv
verification/exec_pipeline_assert.sv
verification/tb_exec_pipeline.sv
